//--- design/bb_defs.svh
`ifndef BB_DEFS_SVH
`define BB_DEFS_SVH

// Complementary filter weights
`define BB_GYRO_SHIFT 4'd6     // Gyro rate to per-sample angle step
`define BB_ALPHA_SHIFT 4'd4    // Accel correction weight of 1/16

// PD controller gains as right shifts
`define BB_KP_SHIFT 4'd3
`define BB_KD_SHIFT 4'd2

// Servo and PWM
`define BB_DUTY_CENTER 8'd128  // Platform level
`define BB_PWM_PERIOD 1024     // Clocks per servo frame

// IR grid scan
`define BB_SCAN_DIV 64         // Clocks between grid samples
`define BB_SETPOINT_STEP 16'sd256  // Setpoint units per cell

`endif

//--- design/bb_pkg.sv
package bb_pkg;

    // One decoded IMU frame with the first word on top
    typedef struct packed {
        logic signed [15:0] accel_x;
        logic signed [15:0] accel_y;
        logic signed [15:0] accel_z;   // Carried but not fused
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
    } imu_sample_t;

    // Fused platform angles
    typedef struct packed {
        logic signed [15:0] roll;      // Drives X axis
        logic signed [15:0] pitch;     // Drives Y axis
    } tilt_t;

    // Ball position on the 5x8 grid
    typedef struct packed {
        logic               detected;
        logic [2:0]         x;         // Column 0..4
        logic [2:0]         y;         // Row 0..7
        logic signed [15:0] setpoint_x;
        logic signed [15:0] setpoint_y;
    } ball_t;

    // Servo duties for both axes
    typedef struct packed {
        logic [7:0] duty_x;
        logic [7:0] duty_y;
    } duty_t;

endpackage

//--- design/imu_frame_decoder.sv
`timescale 1ns/1ps

module imu_frame_decoder (
    input  logic                hz100,
    input  logic                arst_n,
    input  logic [79:0]         frame,        // Five big-endian words
    input  logic                frame_valid,  // One-cycle strobe
    output bb_pkg::imu_sample_t sample,
    output logic                sample_valid
);

    // Payload register loaded on each strobe
    always_ff @(posedge hz100) begin
        if (frame_valid) begin
            // Raw words are already two's complement
            sample.accel_x <= $signed(frame[79:64]);
            sample.accel_y <= $signed(frame[63:48]);
            sample.accel_z <= $signed(frame[47:32]);
            sample.gyro_x  <= $signed(frame[31:16]);
            sample.gyro_y  <= $signed(frame[15:0]);
        end
    end

    // Strobe follows capture by one clock
    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_valid;  // Back-to-back frames keep it high
        end
    end

endmodule

//--- design/ball_locator.sv
`timescale 1ns/1ps
`include "bb_defs.svh"

module ball_locator (
    input  logic          hz100,
    input  logic          arst_n,
    input  logic [39:0]   ir_rows,  // Bit 5y+x is cell (x, y)
    output bb_pkg::ball_t ball
);

    localparam int unsigned DIV_W = $clog2(`BB_SCAN_DIV);

    logic [DIV_W-1:0]   div_cnt;   // Free-running scan divider
    logic               scan_tick;
    logic               found;
    logic [2:0]         hit_x;
    logic [2:0]         hit_y;
    logic signed [15:0] cell_x;    // Offset from grid center
    logic signed [15:0] cell_y;

    assign scan_tick = (div_cnt == DIV_W'(`BB_SCAN_DIV - 1));
    assign found     = |ir_rows;

    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (scan_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Walk down from the top cell so the lowest set bit wins
    always_comb begin
        hit_x = 3'd0;
        hit_y = 3'd0;
        for (int y = 7; y >= 0; y--) begin
            for (int x = 4; x >= 0; x--) begin
                if (ir_rows[5*y+x]) begin
                    hit_x = 3'(x);
                    hit_y = 3'(y);
                end
            end
        end
        cell_x = {13'd0, hit_x} - 16'sd2;  // Center column is 2
        cell_y = {13'd0, hit_y} - 16'sd4;  // Center row is 4
    end

    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            ball <= '0;
        end else if (scan_tick) begin
            ball.detected <= found;
            if (found) begin  // Empty grid keeps last position
                ball.x          <= hit_x;
                ball.y          <= hit_y;
                ball.setpoint_x <= cell_x * `BB_SETPOINT_STEP;
                ball.setpoint_y <= cell_y * `BB_SETPOINT_STEP;
            end
        end
    end

endmodule

//--- design/tilt_filter.sv
`timescale 1ns/1ps
`include "bb_defs.svh"

module tilt_filter (
    input  logic                hz100,
    input  logic                arst_n,
    input  bb_pkg::imu_sample_t sample,
    input  logic                sample_valid,
    output bb_pkg::tilt_t       tilt,
    output logic                angle_valid
);

    logic signed [15:0] roll_pred;   // Gyro-integrated guess
    logic signed [15:0] pitch_pred;
    logic signed [15:0] roll_err;    // Accel minus guess
    logic signed [15:0] pitch_err;
    logic signed [15:0] roll_next;
    logic signed [15:0] pitch_next;

    // Everything wraps in 16 bits
    always_comb begin
        roll_pred  = tilt.roll + (sample.gyro_x >>> `BB_GYRO_SHIFT);
        pitch_pred = tilt.pitch + (sample.gyro_y >>> `BB_GYRO_SHIFT);
        // Pull toward the accel reading
        roll_err   = sample.accel_y - roll_pred;
        pitch_err  = sample.accel_x - pitch_pred;
        roll_next  = roll_pred + (roll_err >>> `BB_ALPHA_SHIFT);
        pitch_next = pitch_pred + (pitch_err >>> `BB_ALPHA_SHIFT);
    end

    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            tilt        <= '0;   // Platform assumed level
            angle_valid <= 1'b0;
        end else begin
            angle_valid <= sample_valid;
            if (sample_valid) begin
                tilt.roll  <= roll_next;
                tilt.pitch <= pitch_next;
            end
        end
    end

endmodule

//--- design/axis_pid.sv
`timescale 1ns/1ps
`include "bb_defs.svh"

module axis_pid (
    input  logic               hz100,
    input  logic               arst_n,
    input  logic               angle_valid,
    input  logic signed [15:0] tilt,
    input  logic signed [15:0] setpoint,
    output logic [7:0]         duty
);

    logic signed [16:0] err;       // Setpoint minus tilt without overflow
    logic signed [16:0] err_prev;
    logic signed [17:0] err_diff;
    logic signed [16:0] p_term;
    logic signed [17:0] d_term;
    logic signed [18:0] sum;       // Center plus both terms
    logic [7:0]         duty_next;

    always_comb begin
        err      = {setpoint[15], setpoint} - {tilt[15], tilt};
        err_diff = {err[16], err} - {err_prev[16], err_prev};
        p_term   = err >>> `BB_KP_SHIFT;
        d_term   = err_diff >>> `BB_KD_SHIFT;
        sum      = $signed({11'd0, `BB_DUTY_CENTER}) + p_term + d_term;
        // Saturate to servo range
        if (sum < 0) begin
            duty_next = 8'd0;
        end else if (sum > 19'sd255) begin
            duty_next = 8'd255;
        end else begin
            duty_next = sum[7:0];
        end
    end

    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            duty     <= `BB_DUTY_CENTER;
            err_prev <= '0;
        end else if (angle_valid) begin
            duty     <= duty_next;
            err_prev <= err;  // For next derivative
        end
    end

endmodule

//--- design/servo_pwm.sv
`timescale 1ns/1ps
`include "bb_defs.svh"

module servo_pwm (
    input  logic       hz100,
    input  logic       arst_n,
    input  logic [7:0] duty,
    output logic       pwm
);

    localparam int unsigned PWM_W = $clog2(`BB_PWM_PERIOD);

    logic [PWM_W-1:0] cnt;      // Position within period
    logic [7:0]       duty_q;   // Duty held for whole period
    logic             wrap;

    assign wrap = (cnt == PWM_W'(`BB_PWM_PERIOD - 1));

    always_ff @(posedge hz100 or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            duty_q <= `BB_DUTY_CENTER;
        end else if (wrap) begin
            cnt    <= '0;
            duty_q <= duty;  // Takes effect at count 0
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // High for 4*duty clocks from period start
    assign pwm = (cnt[PWM_W-1:2] < duty_q);

endmodule

//--- design/balance_top.sv
`timescale 1ns/1ps

module balance_top (
    input  logic          hz100,
    input  logic          arst_n,
    input  logic [79:0]   frame,
    input  logic          frame_valid,
    input  logic [39:0]   ir_rows,
    output bb_pkg::tilt_t tilt,
    output logic          angle_valid,
    output bb_pkg::ball_t ball,
    output bb_pkg::duty_t duty,
    output logic          pwm_x,
    output logic          pwm_y
);

    bb_pkg::imu_sample_t sample;
    logic                sample_valid;
    logic [7:0]          duty_x;
    logic [7:0]          duty_y;

    assign duty.duty_x = duty_x;
    assign duty.duty_y = duty_y;

    // Decode
    imu_frame_decoder u_decoder (
        .hz100(hz100), .arst_n(arst_n),
        .frame(frame), .frame_valid(frame_valid),
        .sample(sample), .sample_valid(sample_valid)
    );

    ball_locator u_locator (.hz100(hz100), .arst_n(arst_n), .ir_rows(ir_rows), .ball(ball));

    // Execute
    tilt_filter u_filter (
        .hz100(hz100), .arst_n(arst_n),
        .sample(sample), .sample_valid(sample_valid),
        .tilt(tilt), .angle_valid(angle_valid)
    );

    axis_pid pid_x (
        .hz100(hz100), .arst_n(arst_n), .angle_valid(angle_valid),
        .tilt(tilt.roll), .setpoint(ball.setpoint_x), .duty(duty_x)   // Roll on X
    );

    axis_pid pid_y (
        .hz100(hz100), .arst_n(arst_n), .angle_valid(angle_valid),
        .tilt(tilt.pitch), .setpoint(ball.setpoint_y), .duty(duty_y)  // Pitch on Y
    );

    // Result
    servo_pwm pwm_gen_x (.hz100(hz100), .arst_n(arst_n), .duty(duty_x), .pwm(pwm_x));
    servo_pwm pwm_gen_y (.hz100(hz100), .arst_n(arst_n), .duty(duty_y), .pwm(pwm_y));

endmodule

//--- dv/balance_props.sv
`timescale 1ns/1ps

module balance_props (
    input logic          hz100,
    input logic          arst_n,
    input logic          sample_valid,
    input logic          angle_valid,
    input bb_pkg::duty_t duty
);

    // Filter stage is one clock deep
    a_valid_follows: assert property (@(posedge hz100) disable iff (!arst_n)
        angle_valid == $past(sample_valid))
        else $error("angle_valid did not follow sample_valid by one clock");

    // PID output moves only after a new angle
    a_duty_steady: assert property (@(posedge hz100) disable iff (!arst_n)
        (duty != $past(duty)) |-> $past(angle_valid))
        else $error("duty changed without a preceding angle_valid");

    a_quiet_in_reset: assert property (@(posedge hz100) !arst_n |-> !angle_valid)
        else $error("angle_valid high during reset");

endmodule

bind balance_top balance_props u_props (.hz100, .arst_n, .sample_valid, .angle_valid, .duty);

//--- dv/balance_tb.sv
`timescale 1ns/1ps
`include "bb_defs.svh"

module balance_tb;

    localparam int ROUNDS     = 25;
    localparam int FRAMES     = 12;  // Frames in each round
    localparam int ROUND_CLKS = 2 * `BB_SCAN_DIV + 4 * FRAMES + 2 * `BB_PWM_PERIOD + 40;

    logic          hz100 = 1'b0;
    logic          arst_n;
    logic [79:0]   frame;
    logic          frame_valid;
    logic [39:0]   ir_rows;
    bb_pkg::tilt_t tilt;
    logic          angle_valid;
    bb_pkg::ball_t ball;
    bb_pkg::duty_t duty;
    logic          pwm_x;
    logic          pwm_y;

    bb_pkg::tilt_t m_tilt;         // Reference model state
    bb_pkg::ball_t m_ball;
    bb_pkg::duty_t m_duty;         // Duty the DUT should show now
    int            m_err_x;        // Previous PID errors
    int            m_err_y;
    bb_pkg::tilt_t tilt_q[$];      // Expected results in frame order
    bb_pkg::duty_t duty_q[$];
    int            pwm_phase = 0;  // Tracks the servo counter
    logic [1:0]    fv_hist = '0;
    logic          av_d1 = 1'b0;
    int            n_checks = 0;
    int            n_mismatch = 0;
    int            n_other = 0;

    balance_top uut (.hz100, .arst_n, .frame, .frame_valid, .ir_rows, .tilt, .angle_valid,
                     .ball, .duty, .pwm_x, .pwm_y);

    always #50 hz100 = ~hz100;

    // One complementary filter step wrapping in 16 bits
    function automatic logic signed [15:0] fuse(input logic signed [15:0] prev,
                                                input logic signed [15:0] rate,
                                                input logic signed [15:0] accel);
        logic signed [15:0] pred;
        logic signed [15:0] diff;
        pred = prev + (rate >>> `BB_GYRO_SHIFT);
        diff = accel - pred;
        return pred + (diff >>> `BB_ALPHA_SHIFT);
    endfunction

    function automatic logic [7:0] pd_duty(input int err, input int prev);
        int sum;
        sum = int'(`BB_DUTY_CENTER) + (err >>> `BB_KP_SHIFT) + ((err - prev) >>> `BB_KD_SHIFT);
        if (sum < 0) begin
            return 8'd0;
        end
        return (sum > 255) ? 8'd255 : 8'(sum);  // Servo range
    endfunction

    // Lowest set cell wins and an empty grid keeps the last position
    task automatic locate(input logic [39:0] cells);
        int i;
        m_ball.detected = (cells != '0);
        if (cells != '0) begin
            i = 0;
            while (!cells[i]) begin
                i++;
            end
            m_ball.x          = 3'(i % 5);
            m_ball.y          = 3'(i / 5);
            m_ball.setpoint_x = 16'((i % 5 - 2) * 256);
            m_ball.setpoint_y = 16'((i / 5 - 4) * 256);
        end
    endtask

    task automatic send_frames(input int count);
        logic [79:0]   f;
        int            err;
        bb_pkg::duty_t d;
        for (int k = 0; k < count; k++) begin
            f = 80'({$urandom, $urandom, $urandom});
            // Words in order accel_x, accel_y, accel_z, gyro_x, gyro_y
            m_tilt.roll  = fuse(m_tilt.roll, f[31:16], f[63:48]);
            m_tilt.pitch = fuse(m_tilt.pitch, f[15:0], f[79:64]);
            err = int'(m_ball.setpoint_x) - int'(m_tilt.roll);
            d.duty_x = pd_duty(err, m_err_x);
            m_err_x  = err;
            err = int'(m_ball.setpoint_y) - int'(m_tilt.pitch);
            d.duty_y = pd_duty(err, m_err_y);
            m_err_y  = err;
            duty_q.push_back(d);
            tilt_q.push_back(m_tilt);
            @(posedge hz100);
            frame       <= f;
            frame_valid <= 1'b1;
            if ($urandom % 2 == 0) begin  // Otherwise back to back
                @(posedge hz100);
                frame_valid <= 1'b0;
                repeat ($urandom % 3) @(posedge hz100);
            end
        end
        @(posedge hz100);
        frame_valid <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((tilt_q.size() != 0 || duty_q.size() != 0) && waited < 10) begin
            @(posedge hz100);
            waited++;
        end
        assert (tilt_q.size() == 0 && duty_q.size() == 0) else begin
            n_other++;
            $display("Error at %0d ns: results for %0d frames never came out", $time,
                     duty_q.size());
        end
    endtask

    // High clocks over one whole period from the counter wrap
    task automatic check_pwm();
        int high_x;
        int high_y;
        high_x = 0;
        high_y = 0;
        repeat (2) @(negedge hz100);  // Last duty reaches the latch
        while (pwm_phase != 0) begin
            @(negedge hz100);
        end
        repeat (`BB_PWM_PERIOD) begin
            high_x += int'(pwm_x);
            high_y += int'(pwm_y);
            @(negedge hz100);
        end
        n_checks++;
        assert (high_x == 4 * m_duty.duty_x && high_y == 4 * m_duty.duty_y) else begin
            n_mismatch++;
            $display("Mismatch at %0d ns: pwm high clocks %0d/%0d, expected %0d/%0d", $time,
                     high_x, high_y, 4 * m_duty.duty_x, 4 * m_duty.duty_y);
        end
    endtask

    always @(posedge hz100) begin
        pwm_phase <= !arst_n ? 0 : (pwm_phase + 1) % `BB_PWM_PERIOD;
    end

    always @(negedge hz100) begin : monitor
        bb_pkg::tilt_t exp_t;
        if (!arst_n) begin
            fv_hist = '0;
            av_d1   = 1'b0;
        end else begin
            n_checks++;
            assert (angle_valid == fv_hist[1]) else begin  // Two clocks after the strobe
                n_mismatch++;
                $display("Mismatch at %0d ns: angle_valid=%0b, strobe two clocks back=%0b",
                         $time, angle_valid, fv_hist[1]);
            end
            if (angle_valid) begin
                assert (tilt_q.size() != 0) else begin
                    n_other++;
                    $display("Error at %0d ns: angle_valid with no frame outstanding", $time);
                end
                if (tilt_q.size() != 0) begin
                    exp_t = tilt_q.pop_front();
                    assert (tilt == exp_t) else begin
                        n_mismatch++;
                        $display("Mismatch at %0d ns: tilt %0d/%0d, expected %0d/%0d", $time,
                                 tilt.roll, tilt.pitch, exp_t.roll, exp_t.pitch);
                    end
                end
            end
            if (av_d1 && duty_q.size() != 0) begin
                m_duty = duty_q.pop_front();
            end
            assert (duty == m_duty) else begin
                n_mismatch++;
                $display("Mismatch at %0d ns: duty %0d/%0d, expected %0d/%0d", $time,
                         duty.duty_x, duty.duty_y, m_duty.duty_x, m_duty.duty_y);
            end
            av_d1   = angle_valid;
            fv_hist = {fv_hist[0], frame_valid};
        end
    end

    initial begin
        #((8 + ROUNDS * ROUND_CLKS) * 100 + 50_000);
        n_other++;
        $display("Error at %0d ns: watchdog expired before the tests finished", $time);
        $display("Checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [39:0] cells;
        void'($urandom(52));
        arst_n      = 1'b0;
        frame       = '0;
        frame_valid = 1'b0;
        ir_rows     = '0;
        m_tilt      = '0;
        m_ball      = '0;
        m_duty      = {`BB_DUTY_CENTER, `BB_DUTY_CENTER};
        m_err_x     = 0;
        m_err_y     = 0;
        repeat (8) @(posedge hz100);
        arst_n <= 1'b1;
        @(negedge hz100);
        n_checks++;
        assert (tilt == '0 && !angle_valid && !ball.detected && ball.setpoint_x == 0
                && ball.setpoint_y == 0 && duty == {8'd128, 8'd128}) else begin
            n_mismatch++;
            $display("Mismatch at %0d ns: after reset tilt=%h ball=%h duty=%h", $time,
                     tilt, ball, duty);
        end
        for (int r = 0; r < ROUNDS; r++) begin
            cells = 40'({$urandom, $urandom});
            case (r % 5)
                0: cells = '0;                                 // Hold check
                1: cells = 40'd1 << ($urandom % 40);
                2: cells = cells & 40'({$urandom, $urandom});  // Sparse
                default: ;
            endcase
            locate(cells);
            @(posedge hz100);
            ir_rows <= cells;
            repeat (2 * `BB_SCAN_DIV) @(posedge hz100);
            @(negedge hz100);
            n_checks++;
            assert (ball == m_ball) else begin
                n_mismatch++;
                $display("Mismatch at %0d ns: ball %h for grid %h, expected %h", $time,
                         ball, cells, m_ball);
            end
            send_frames(FRAMES);
            drain();
            check_pwm();
        end
        $display("Checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+design
design/bb_pkg.sv
design/imu_frame_decoder.sv
design/ball_locator.sv
design/tilt_filter.sv
design/axis_pid.sv
design/servo_pwm.sv
design/balance_top.sv
dv/balance_props.sv
dv/balance_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the balance testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module balance_tb \
    -f filelist.f -o balance_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/balance_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
